//--- hdl/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// ##############################
// Front end constants
// ##############################

// PC loaded on reset
`define RESET_PC 32'h0000_0000

// add x0, x0, x0 marks an empty pipeline slot
`define NOP_INST 32'h0000_0033

`define PC_STEP 32'd4

`endif

//--- hdl/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

	// ##############################
	// Fetch to decode
	// ##############################

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_packet_t;

	// ##############################
	// Decode results
	// ##############################

	// Base ISA encoding formats
	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} inst_format_e;

	typedef struct packed {
		logic [31:0]  pc;
		logic [6:0]   opcode;
		logic [4:0]   rd;
		logic [2:0]   funct3;
		logic [4:0]   rs1;
		logic [4:0]   rs2;
		logic [6:0]   funct7;
		// Sign-extended, already shifted for B, U and J
		logic [31:0]  imm;
		inst_format_e format;
		logic         illegal;
	} decoded_t;

endpackage

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_macros.svh"

module fetch_stage (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  stall,

	input  wire logic                  mem_ready,
	input  wire logic                  mem_data_valid,
	input  wire logic [31:0]           mem_data,
	output logic                       mem_start,
	output logic [31:0]                mem_addr,

	output logic                       fetch_valid,
	output frontend_pkg::fetch_packet_t fetch_packet
);

	typedef enum logic {
		ST_ISSUE = 1'b0,
		ST_WAIT  = 1'b1
	} state_t;

	state_t      state;
	logic [31:0] pc;

	// Word that came back while the pipeline was stalled
	logic [31:0] hold_inst;
	logic        pending;

	logic        bypass;
	logic        issue;

	// ##############################
	// Output toward decode
	// ##############################

	// A returning word goes straight through when nothing is stalled
	assign bypass = (state == ST_WAIT) && mem_data_valid && !stall;

	assign fetch_valid = bypass || (pending && !stall);

	// The PC only moves after a word is handed on, so it still names the word in flight
	assign fetch_packet.pc = pc;

	always_comb begin
		if (!fetch_valid) begin
			fetch_packet.inst = `NOP_INST;
		end else if (pending) begin
			fetch_packet.inst = hold_inst;
		end else begin
			fetch_packet.inst = mem_data;
		end
	end

	// ##############################
	// Memory side
	// ##############################

	assign mem_addr = pc;

	// A held word must be drained before the next read goes out
	assign issue = (state == ST_ISSUE) && !pending && !stall && mem_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_ISSUE;
			pc        <= `RESET_PC;
			pending   <= 1'b0;
			mem_start <= 1'b0;
		end else begin
			case (state)
				ST_ISSUE: begin
					if (issue) begin
						mem_start <= 1'b1;
						state     <= ST_WAIT;
					end
					if (pending && !stall) begin
						pending <= 1'b0;
					end
				end
				ST_WAIT: begin
					mem_start <= 1'b0;
					if (mem_data_valid) begin
						state <= ST_ISSUE;
						if (stall) begin
							pending <= 1'b1;
						end
					end
				end
				default: begin
					state <= ST_ISSUE;
				end
			endcase

			if (fetch_valid) begin
				pc <= pc + `PC_STEP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT && mem_data_valid && stall) begin
			hold_inst <= mem_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire logic     stall,
	input  wire logic     in_valid,
	input  wire payload_t in_data,
	output logic          out_valid,
	output payload_t      out_data
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  wire frontend_pkg::fetch_packet_t packet,
	output frontend_pkg::decoded_t           decoded
);

	// ##############################
	// RV32I base opcodes
	// ##############################

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	logic [31:0]                inst;
	frontend_pkg::inst_format_e format;
	logic                       illegal;
	logic [31:0]                imm;

	assign inst = packet.inst;

	always_comb begin
		illegal = 1'b0;
		case (inst[6:0])
			OP_LUI, OP_AUIPC: format = frontend_pkg::FMT_U;
			OP_JAL:           format = frontend_pkg::FMT_J;
			OP_BRANCH:        format = frontend_pkg::FMT_B;
			OP_STORE:         format = frontend_pkg::FMT_S;
			OP_REG:           format = frontend_pkg::FMT_R;
			OP_JALR, OP_LOAD, OP_IMM, OP_FENCE, OP_SYSTEM: begin
				format = frontend_pkg::FMT_I;
			end
			default: begin
				// Unknown opcodes decode as R so they carry no immediate
				format  = frontend_pkg::FMT_R;
				illegal = 1'b1;
			end
		endcase
	end

	// ##############################
	// Immediate assembly
	// ##############################

	always_comb begin
		case (format)
			frontend_pkg::FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
			frontend_pkg::FMT_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			frontend_pkg::FMT_B: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			frontend_pkg::FMT_U: imm = {inst[31:12], 12'h000};
			frontend_pkg::FMT_J: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: imm = 32'h0000_0000;
		endcase
	end

	// Register and function fields are taken raw whatever the format
	assign decoded.pc      = packet.pc;
	assign decoded.opcode  = inst[6:0];
	assign decoded.rd      = inst[11:7];
	assign decoded.funct3  = inst[14:12];
	assign decoded.rs1     = inst[19:15];
	assign decoded.rs2     = inst[24:20];
	assign decoded.funct7  = inst[31:25];
	assign decoded.imm     = imm;
	assign decoded.format  = format;
	assign decoded.illegal = illegal;

endmodule

`default_nettype wire

//--- hdl/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             stall,

	input  wire logic             mem_ready,
	input  wire logic             mem_data_valid,
	input  wire logic [31:0]      mem_data,
	output logic                  mem_start,
	output logic [31:0]           mem_addr,

	output logic                  dec_valid,
	output frontend_pkg::decoded_t dec_out
);

	logic                        fetch_valid;
	frontend_pkg::fetch_packet_t fetch_packet;

	logic                        id_valid;
	frontend_pkg::fetch_packet_t id_packet;

	frontend_pkg::decoded_t      id_decoded;

	// ##############################
	// Fetch
	// ##############################

	fetch_stage i_fetch_stage (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.mem_ready      (mem_ready),
		.mem_data_valid (mem_data_valid),
		.mem_data       (mem_data),
		.mem_start      (mem_start),
		.mem_addr       (mem_addr),
		.fetch_valid    (fetch_valid),
		.fetch_packet   (fetch_packet)
	);

	stage_reg #(
		.payload_t (frontend_pkg::fetch_packet_t)
	) i_if_id_reg (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.in_valid  (fetch_valid),
		.in_data   (fetch_packet),
		.out_valid (id_valid),
		.out_data  (id_packet)
	);

	// ##############################
	// Decode
	// ##############################

	inst_decoder i_inst_decoder (
		.packet  (id_packet),
		.decoded (id_decoded)
	);

	stage_reg #(
		.payload_t (frontend_pkg::decoded_t)
	) i_id_out_reg (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.in_valid  (id_valid),
		.in_data   (id_decoded),
		.out_valid (dec_valid),
		.out_data  (dec_out)
	);

endmodule

`default_nettype wire

//--- verif/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "frontend_macros.svh"

module frontend_tb;

	// Columns of one stimulus line
	localparam int COL_WORD   = 0;
	localparam int COL_LAT    = 1;
	localparam int COL_STALL  = 2;
	localparam int COL_OPCODE = 3;
	localparam int COL_RD     = 4;
	localparam int COL_RS1    = 5;
	localparam int COL_RS2    = 6;
	localparam int COL_F3     = 7;
	localparam int COL_F7     = 8;
	localparam int COL_IMM    = 9;
	localparam int COL_FMT    = 10;
	localparam int COL_ILL    = 11;

	localparam int MAX_LINES       = 64;
	localparam int CYCLES_PER_LINE = 20;

	logic                   clk;
	logic                   reset;
	logic                   stall;
	logic                   mem_ready;
	logic                   mem_data_valid;
	logic [31:0]            mem_data;
	logic                   mem_start;
	logic [31:0]            mem_addr;
	logic                   dec_valid;
	frontend_pkg::decoded_t dec_out;

	logic [31:0] stim [MAX_LINES][12];
	int          n_lines;
	int          cycle_limit;
	int          cycle_cnt;
	int          seed;
	int          issue_idx;
	int          req_idx;
	int          delay_cnt;
	int          stall_cnt;
	int          checked;
	logic        busy;
	logic        late_stall;
	int          pend_q[$];

	frontend_top i_frontend_top (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.mem_ready      (mem_ready),
		.mem_data_valid (mem_data_valid),
		.mem_data       (mem_data),
		.mem_start      (mem_start),
		.mem_addr       (mem_addr),
		.dec_valid      (dec_valid),
		.dec_out        (dec_out)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, got, expected));
		end
	endtask

	task automatic load_stimulus();
		int    fd;
		int    fields;
		string line;
		fd = $fopen("verif/frontend_stimulus.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the stimulus file verif/frontend_stimulus.txt");
		end
		n_lines = 0;
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
					stim[n_lines][0], stim[n_lines][1], stim[n_lines][2], stim[n_lines][3],
					stim[n_lines][4], stim[n_lines][5], stim[n_lines][6], stim[n_lines][7],
					stim[n_lines][8], stim[n_lines][9], stim[n_lines][10], stim[n_lines][11]);
				if (fields != 12) begin
					abort_run($sformatf("Stimulus line %0d does not have 12 columns", n_lines));
				end
				n_lines++;
			end
		end
		$fclose(fd);
		if (n_lines == 0) begin
			abort_run("The stimulus file holds no instruction lines");
		end
	endtask

	// Pairs the decoded slot with the oldest fetched line
	task automatic score_decoded();
		int line_idx;
		if (pend_q.size() == 0) begin
			abort_run("dec_valid was seen while no fetched word was outstanding");
		end
		line_idx = pend_q.pop_front();
		check_value("dec_out.pc", dec_out.pc, `RESET_PC + `PC_STEP * line_idx);
		check_value("dec_out.opcode", 32'(dec_out.opcode), stim[line_idx][COL_OPCODE]);
		check_value("dec_out.rd", 32'(dec_out.rd), stim[line_idx][COL_RD]);
		check_value("dec_out.rs1", 32'(dec_out.rs1), stim[line_idx][COL_RS1]);
		check_value("dec_out.rs2", 32'(dec_out.rs2), stim[line_idx][COL_RS2]);
		check_value("dec_out.funct3", 32'(dec_out.funct3), stim[line_idx][COL_F3]);
		check_value("dec_out.funct7", 32'(dec_out.funct7), stim[line_idx][COL_F7]);
		check_value("dec_out.imm", dec_out.imm, stim[line_idx][COL_IMM]);
		check_value("dec_out.format", 32'(dec_out.format), stim[line_idx][COL_FMT]);
		check_value("dec_out.illegal", 32'(dec_out.illegal), stim[line_idx][COL_ILL]);
		checked++;
		if (checked == n_lines) begin
			$display("test passed");
			$finish;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		reset          = 1'b1;
		stall          = 1'b0;
		mem_ready      = 1'b0;
		mem_data_valid = 1'b0;
		mem_data       = 32'h0000_0000;
		seed           = 33501;
		cycle_cnt      = 0;
		issue_idx      = 0;
		req_idx        = 0;
		delay_cnt      = 0;
		stall_cnt      = 0;
		checked        = 0;
		busy           = 1'b0;
		late_stall     = 1'b0;
		load_stimulus();
		cycle_limit = n_lines * CYCLES_PER_LINE;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

	// ##############################
	// Memory model, stall driver and scoreboard
	// ##############################

	always @(posedge clk) begin
		if (!reset) begin
			cycle_cnt++;
			if (cycle_cnt > cycle_limit) begin
				abort_run($sformatf("Timeout after %0d cycles with %0d of %0d lines decoded",
					cycle_limit, checked, n_lines));
			end
			if (cycle_cnt == 1) begin
				check_value("mem_start", {31'd0, mem_start}, 32'd0);
				check_value("dec_valid", {31'd0, dec_valid}, 32'd0);
				check_value("mem_addr", mem_addr, `RESET_PC);
			end

			// Ready drops for roughly one cycle in eight
			mem_ready      <= (($random(seed) & 7) != 0);
			mem_data_valid <= 1'b0;

			if (stall_cnt != 0) begin
				if (late_stall) begin
					late_stall = 1'b0;
					stall <= 1'b1;
				end else begin
					stall_cnt--;
					if (stall_cnt == 0) begin
						stall <= 1'b0;
					end
				end
			end

			if (delay_cnt != 0) begin
				delay_cnt--;
				if (delay_cnt == 0) begin
					mem_data_valid <= 1'b1;
					busy = 1'b0;
					pend_q.push_back(req_idx);
					if (req_idx < n_lines) begin
						mem_data  <= stim[req_idx][COL_WORD];
						stall_cnt = stim[req_idx][COL_STALL];
						// Every other pair of lines starts its stall one cycle after the return
						late_stall = !req_idx[1];
						if (stall_cnt != 0 && !late_stall) begin
							stall <= 1'b1;
						end
					end else begin
						mem_data <= `NOP_INST;
					end
				end
			end

			if (mem_start) begin
				check_value("mem_start during stall", {31'd0, stall}, 32'd0);
				check_value("mem_start with a read outstanding", {31'd0, busy}, 32'd0);
				check_value("mem_addr", mem_addr, `RESET_PC + `PC_STEP * issue_idx);
				req_idx = issue_idx;
				issue_idx++;
				busy = 1'b1;
				delay_cnt = (req_idx < n_lines) ? stim[req_idx][COL_LAT] : 1;
			end

			if (dec_valid && !stall) begin
				score_decoded();
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/frontend_stimulus.txt
# word lat stall opcode rd rs1 rs2 funct3 funct7 imm format illegal, all in hex
# format codes are 0 R, 1 I, 2 S, 3 B, 4 U, 5 J
002081b3 1 0 33 03 01 02 0 00 00000000 0 0
407302b3 2 0 33 05 06 07 0 20 00000000 0 0
fff00093 4 3 13 01 00 1f 0 7f ffffffff 1 0
00812503 1 1 03 0a 02 08 2 00 00000008 1 0
fe512e23 3 0 23 1c 02 05 2 7f fffffffc 2 0
00208863 2 5 63 10 01 02 0 00 00000010 3 0
fe419ce3 1 0 63 19 03 04 1 7f fffffff8 3 0
123453b7 4 2 37 07 08 03 5 09 12345000 4 0
fffff117 1 0 17 02 1f 1f 7 7f fffff000 4 0
001000ef 3 4 6f 01 00 01 0 00 00000800 5 0
ffdff06f 2 0 6f 00 1f 1d 7 7f fffffffc 5 0
000280e7 1 2 67 01 05 00 0 00 00000000 1 0
0000000b 4 0 0b 00 00 00 0 00 00000000 0 1
80027213 2 1 13 04 04 00 7 40 fffff800 1 0
00000073 1 0 73 00 00 00 0 00 00000000 1 0
ffffffff 3 3 7f 1f 1f 1f 7 7f 00000000 0 1

//--- verilog.f
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_stage.sv
hdl/stage_reg.sv
hdl/inst_decoder.sv
hdl/frontend_top.sv
verif/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the front end testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module frontend_tb -f verilog.f -o frontend_sim \
	&& ./obj_dir/frontend_sim | tee sim.log \
	|| { echo "Build or simulation error"; exit 1; }
grep -qx "test passed" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
